// ==== verilog/simd_wrap_macros.svh ====
//----------------------------------------------------------------------------
// Sizes for the SIMD wrapper. Each result FIFO threshold must leave room
// for the words already in flight when result_ready drops.
// The FIFO depths are assumed to be powers of two.
//----------------------------------------------------------------------------
`ifndef SIMD_WRAP_MACROS_SVH
`define SIMD_WRAP_MACROS_SVH

// Lane geometry
`define NUM_LANES              4
`define LANE_WIDTH             32
`define CNTL_WIDTH             2

// Tag fields
`define TAG_WIDTH              8
`define OPTION_PTR_WIDTH       4
`define LANE_COUNT_WIDTH       3

// Per-lane result FIFOs
`define RESULT_FIFO_DEPTH      8
`define RESULT_FIFO_THRESHOLD  6

// Tag FIFO
`define TAG_FIFO_DEPTH         4
`define TAG_FIFO_THRESHOLD     2

// Option table entries, one per option pointer value
`define OPTION_MEM_DEPTH       16

`endif

// ==== verilog/simd_wrap_pkg.sv ====
//----------------------------------------------------------------------------
// Types shared by the SIMD wrapper blocks. MAX_SCALAR compares unsigned.
//----------------------------------------------------------------------------
`include "simd_wrap_macros.svh"

package simd_wrap_pkg;

  typedef logic [`LANE_WIDTH-1:0]        lane_data_t;
  typedef logic [`CNTL_WIDTH-1:0]        lane_cntl_t;
  typedef logic [`NUM_LANES-1:0]         lane_mask_t;
  typedef logic [`TAG_WIDTH-1:0]         tag_t;
  typedef logic [`OPTION_PTR_WIDTH-1:0]  option_ptr_t;
  typedef logic [`LANE_COUNT_WIDTH-1:0]  lane_count_t;

  // Lane operations, each applied against the scalar operand
  typedef enum logic [2:0]
  {
    PASS,
    ADD_SCALAR,
    SUB_SCALAR,
    MAX_SCALAR,
    AND_SCALAR
  } simd_op_e;

  // An all-zero entry is disabled with PASS
  typedef struct packed
  {
    logic      enable;
    simd_op_e  operation;
  } option_entry_t;

  // Upstream control FSM
  typedef enum logic [2:0]
  {
    WAIT,
    CHECK_ENABLE,
    WAIT_SIMD_START,
    WAIT_SIMD_COMPLETE,
    SEND_DATA,
    WAIT_COMPLETE,
    WAIT_COMPLETE_LOW,
    DONE
  } upstream_state_e;

endpackage

// ==== verilog/lane_result_if.sv ====
//----------------------------------------------------------------------------
// Head words of the lane result FIFOs, seen by the upstream FSM and the
// lane unit. The lane unit only looks at the words and never pops them.
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "simd_wrap_macros.svh"

interface lane_result_if
  import simd_wrap_pkg::*;
  ();

  lane_mask_t  head_valid;
  lane_cntl_t  head_cntl [`NUM_LANES];
  lane_data_t  head_data [`NUM_LANES];

  // One pop strobe per lane
  lane_mask_t  read;

  modport fifo_side (
    output head_valid, head_cntl, head_data,
    input  read
  );

  modport cntl_side (
    input  head_valid, head_cntl, head_data,
    output read
  );

  modport alu_side (
    input  head_cntl, head_data
  );

endinterface

// ==== verilog/pipelined_fifo.sv ====
//----------------------------------------------------------------------------
// Synchronous FIFO with a registered head word. DEPTH must be a power of
// two and at least 2. almost_full is set from THRESHOLD entries on.
// A write shows at the head one cycle later.
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module pipelined_fifo #(
  parameter int DEPTH     = 8,
  parameter int WIDTH     = 32,
  parameter int THRESHOLD = 6
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              write,
  input  logic [WIDTH-1:0]  write_data,
  input  logic              read,
  output logic              head_valid,
  output logic [WIDTH-1:0]  head_data,
  output logic              almost_full
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]  mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W-1:0]  rd_ptr_next;
  logic [CNT_W-1:0]  count;

  assign rd_ptr_next = read ? rd_ptr + 1'b1 : rd_ptr;
  assign head_valid  = (count != '0);
  assign almost_full = (count >= CNT_W'(THRESHOLD));

  // Pointers and occupancy
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (write)
        wr_ptr <= wr_ptr + 1'b1;
      rd_ptr <= rd_ptr_next;
      if (write && !read)
        count <= count + 1'b1;
      else if (read && !write)
        count <= count - 1'b1;
    end
  end

  // Storage and the head word at the next read pointer
  always_ff @(posedge clk)
  begin
    if (write)
      mem[wr_ptr] <= write_data;
    // Word written into an emptied FIFO goes straight to the head
    if (write && (wr_ptr == rd_ptr_next))
      head_data <= write_data;
    else
      head_data <= mem[rd_ptr_next];
  end

  no_write_when_full : assert property (
    @(posedge clk) disable iff (reset) write |-> (count != CNT_W'(DEPTH)));

  no_read_when_empty : assert property (
    @(posedge clk) disable iff (reset) read |-> head_valid);

endmodule

// ==== verilog/simd_option_memory.sv ====
//----------------------------------------------------------------------------
// Option table indexed by the tag's option pointer. Reset clears every
// entry to disabled PASS. The read is combinational and a write is seen
// from the next cycle.
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "simd_wrap_macros.svh"

module simd_option_memory
  import simd_wrap_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           write,
  input  option_ptr_t    write_address,
  input  option_entry_t  write_entry,
  input  option_ptr_t    read_address,
  output option_entry_t  read_entry
);

  option_entry_t  table_q [`OPTION_MEM_DEPTH];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `OPTION_MEM_DEPTH; i++)
        table_q[i] <= '0;
    end
    else if (write)
    begin
      table_q[write_address] <= write_entry;
    end
  end

  assign read_entry = table_q[read_address];

endmodule

// ==== verilog/simd_lane_alu.sv ====
//----------------------------------------------------------------------------
// Lane unit applying one scalar operation to every lane head word.
// processing follows start by one cycle, complete and the results by two.
// Results are held until the next start. Arithmetic wraps modulo 2^32.
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "simd_wrap_macros.svh"

module simd_lane_alu
  import simd_wrap_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  simd_op_e              operation,
  input  lane_data_t            scalar,
  lane_result_if.alu_side       results,
  output logic                  processing,
  output logic                  complete,
  output lane_cntl_t            lane_cntl_out [`NUM_LANES],
  output lane_data_t            lane_data_out [`NUM_LANES]
);

  simd_op_e  op_q;

  function automatic lane_data_t apply_op(simd_op_e op, lane_data_t a, lane_data_t s);
    case (op)
      ADD_SCALAR: return a + s;
      SUB_SCALAR: return a - s;
      MAX_SCALAR: return (a > s) ? a : s;
      AND_SCALAR: return a & s;
      default:    return a;
    endcase
  endfunction

  // Strobe pipeline
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      processing <= 1'b0;
      complete   <= 1'b0;
      op_q       <= PASS;
    end
    else
    begin
      processing <= start;
      complete   <= processing;
      if (start)
        op_q <= operation;
    end
  end

  // Heads are stable until the FSM pops them after complete
  always_ff @(posedge clk)
  begin
    if (processing)
    begin
      for (int i = 0; i < `NUM_LANES; i++)
      begin
        lane_cntl_out[i] <= results.head_cntl[i];
        lane_data_out[i] <= apply_op(op_q, results.head_data[i], scalar);
      end
    end
  end

  no_start_while_busy : assert property (
    @(posedge clk) disable iff (reset) start |-> !processing);

endmodule

// ==== verilog/upstream_cntl.sv ====
//----------------------------------------------------------------------------
// Upstream FSM. A job starts once a tag, every masked lane head and the
// upstream ready are present. regs_valid is high for one cycle per job and
// the next job waits for the upstream complete pulse to end.
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "simd_wrap_macros.svh"

module upstream_cntl
  import simd_wrap_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  lane_mask_t            lane_mask,
  input  logic                  tag_head_valid,
  input  tag_t                  tag_head,
  input  lane_count_t           tag_head_count,
  input  option_entry_t         option,
  lane_result_if.cntl_side      results,
  input  logic                  alu_processing,
  input  logic                  alu_complete,
  input  lane_cntl_t            alu_cntl [`NUM_LANES],
  input  lane_data_t            alu_data [`NUM_LANES],
  input  logic                  regs_ready_d1,
  input  logic                  regs_complete_d1,
  output logic                  alu_start,
  output logic                  tag_read,
  output tag_t                  regs_tag,
  output lane_count_t           regs_lane_count,
  output lane_mask_t            regs_valid,
  output lane_cntl_t            regs_cntl [`NUM_LANES],
  output lane_data_t            regs_data [`NUM_LANES]
);

  upstream_state_e  state;
  upstream_state_e  state_next;
  logic             lanes_ready;
  logic             send_data;

  // Unmasked lanes do not hold up a job
  assign lanes_ready = &(results.head_valid | ~lane_mask);
  assign send_data   = (state == SEND_DATA);
  assign alu_start   = (state == CHECK_ENABLE) && option.enable;
  assign tag_read    = send_data;
  assign results.read = lane_mask & {`NUM_LANES{send_data}};

  // --------------------------------------------------------------------------
  // State sequencing
  // --------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= WAIT;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      WAIT:
        if (tag_head_valid && lanes_ready && regs_ready_d1)
          state_next = CHECK_ENABLE;
      CHECK_ENABLE:
        state_next = option.enable ? WAIT_SIMD_START : SEND_DATA;
      WAIT_SIMD_START:
        if (alu_processing)
          state_next = WAIT_SIMD_COMPLETE;
      WAIT_SIMD_COMPLETE:
        if (alu_complete)
          state_next = SEND_DATA;
      SEND_DATA:
        state_next = WAIT_COMPLETE;
      WAIT_COMPLETE:
        if (regs_complete_d1)
          state_next = WAIT_COMPLETE_LOW;
      WAIT_COMPLETE_LOW:
        if (!regs_complete_d1)
          state_next = DONE;
      default:
        state_next = WAIT;
    endcase
  end

  // --------------------------------------------------------------------------
  // Upstream output registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      regs_valid      <= '0;
      regs_tag        <= '0;
      regs_lane_count <= '0;
      for (int i = 0; i < `NUM_LANES; i++)
      begin
        regs_cntl[i] <= '0;
        regs_data[i] <= '0;
      end
    end
    else
    begin
      regs_valid <= send_data ? lane_mask : '0;
      if (send_data)
      begin
        regs_tag        <= tag_head;
        regs_lane_count <= tag_head_count;
        // Bypass takes the FIFO heads as they are
        for (int i = 0; i < `NUM_LANES; i++)
        begin
          regs_cntl[i] <= option.enable ? alu_cntl[i] : results.head_cntl[i];
          regs_data[i] <= option.enable ? alu_data[i] : results.head_data[i];
        end
      end
    end
  end

  read_only_valid_heads : assert property (
    @(posedge clk) disable iff (reset) (results.read & ~results.head_valid) == '0);

endmodule

// ==== verilog/simd_wrapper.sv ====
//----------------------------------------------------------------------------
// SIMD wrapper between the per-lane streaming results and the stack
// upstream interface. The result source must honor result_ready per lane
// and the tag source must honor tag_ready. rs0 and rs1 are expected to
// stay stable while jobs are queued.
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "simd_wrap_macros.svh"

module simd_wrapper
  import simd_wrap_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  lane_data_t     rs0,
  input  lane_mask_t     rs1,
  input  logic           tag_valid,
  input  tag_t           tag,
  input  option_ptr_t    tag_option_ptr,
  input  lane_count_t    tag_lane_count,
  output logic           tag_ready,
  input  lane_mask_t     result_valid,
  input  lane_cntl_t     result_cntl [`NUM_LANES],
  input  lane_data_t     result_data [`NUM_LANES],
  output lane_mask_t     result_ready,
  input  logic           option_write,
  input  option_ptr_t    option_address,
  input  option_entry_t  option_data,
  output tag_t           regs_tag,
  output lane_count_t    regs_lane_count,
  output lane_mask_t     regs_valid,
  output lane_cntl_t     regs_cntl [`NUM_LANES],
  output lane_data_t     regs_data [`NUM_LANES],
  input  logic           regs_ready,
  input  logic           regs_complete
);

  localparam int LANE_FIFO_W = `CNTL_WIDTH + `LANE_WIDTH;
  localparam int TAG_FIFO_W  = `OPTION_PTR_WIDTH + `LANE_COUNT_WIDTH + `TAG_WIDTH;

  lane_data_t     rs0_q;
  lane_mask_t     rs1_q;
  logic           tag_valid_d1;
  tag_t           tag_d1;
  option_ptr_t    tag_option_ptr_d1;
  lane_count_t    tag_lane_count_d1;
  logic           regs_ready_d1;
  logic           regs_complete_d1;

  logic           tag_head_valid;
  logic           tag_almost_full;
  logic           tag_read;
  tag_t           tag_head;
  option_ptr_t    tag_head_option_ptr;
  lane_count_t    tag_head_count;

  option_entry_t  option_entry;
  logic           alu_start;
  logic           alu_processing;
  logic           alu_complete;
  lane_cntl_t     alu_cntl [`NUM_LANES];
  lane_data_t     alu_data [`NUM_LANES];

  lane_result_if  res_if ();

  // --------------------------------------------------------------------------
  // Input registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rs0_q            <= '0;
      rs1_q            <= '0;
      tag_valid_d1     <= 1'b0;
      regs_ready_d1    <= 1'b0;
      regs_complete_d1 <= 1'b0;
      tag_ready        <= 1'b1;
    end
    else
    begin
      rs0_q            <= rs0;
      rs1_q            <= rs1;
      tag_valid_d1     <= tag_valid;
      regs_ready_d1    <= regs_ready;
      regs_complete_d1 <= regs_complete;
      tag_ready        <= ~tag_almost_full;
    end
  end

  // Tag payload rides along with tag_valid_d1
  always_ff @(posedge clk)
  begin
    tag_d1            <= tag;
    tag_option_ptr_d1 <= tag_option_ptr;
    tag_lane_count_d1 <= tag_lane_count;
  end

  // --------------------------------------------------------------------------
  // Result and tag FIFOs
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < `NUM_LANES; i++)
  begin : g_lane
    logic [LANE_FIFO_W-1:0]  fifo_head;
    logic                    almost_full;

    pipelined_fifo #(
      .DEPTH     (`RESULT_FIFO_DEPTH),
      .WIDTH     (LANE_FIFO_W),
      .THRESHOLD (`RESULT_FIFO_THRESHOLD)
    ) lane_fifo (
      .clk         (clk),
      .reset       (reset),
      .write       (result_valid[i]),
      .write_data  ({result_cntl[i], result_data[i]}),
      .read        (res_if.read[i]),
      .head_valid  (res_if.head_valid[i]),
      .head_data   (fifo_head),
      .almost_full (almost_full)
    );

    assign res_if.head_cntl[i] = fifo_head[LANE_FIFO_W-1:`LANE_WIDTH];
    assign res_if.head_data[i] = fifo_head[`LANE_WIDTH-1:0];
    assign result_ready[i]     = ~almost_full;
  end

  pipelined_fifo #(
    .DEPTH     (`TAG_FIFO_DEPTH),
    .WIDTH     (TAG_FIFO_W),
    .THRESHOLD (`TAG_FIFO_THRESHOLD)
  ) tag_fifo (
    .clk         (clk),
    .reset       (reset),
    .write       (tag_valid_d1),
    .write_data  ({tag_option_ptr_d1, tag_lane_count_d1, tag_d1}),
    .read        (tag_read),
    .head_valid  (tag_head_valid),
    .head_data   ({tag_head_option_ptr, tag_head_count, tag_head}),
    .almost_full (tag_almost_full)
  );

  // --------------------------------------------------------------------------
  // Option table, lane unit and upstream FSM
  // --------------------------------------------------------------------------
  simd_option_memory option_mem (
    .clk           (clk),
    .reset         (reset),
    .write         (option_write),
    .write_address (option_address),
    .write_entry   (option_data),
    .read_address  (tag_head_option_ptr),
    .read_entry    (option_entry)
  );

  simd_lane_alu lane_alu (
    .clk           (clk),
    .reset         (reset),
    .start         (alu_start),
    .operation     (option_entry.operation),
    .scalar        (rs0_q),
    .results       (res_if.alu_side),
    .processing    (alu_processing),
    .complete      (alu_complete),
    .lane_cntl_out (alu_cntl),
    .lane_data_out (alu_data)
  );

  upstream_cntl cntl (
    .clk              (clk),
    .reset            (reset),
    .lane_mask        (rs1_q),
    .tag_head_valid   (tag_head_valid),
    .tag_head         (tag_head),
    .tag_head_count   (tag_head_count),
    .option           (option_entry),
    .results          (res_if.cntl_side),
    .alu_processing   (alu_processing),
    .alu_complete     (alu_complete),
    .alu_cntl         (alu_cntl),
    .alu_data         (alu_data),
    .regs_ready_d1    (regs_ready_d1),
    .regs_complete_d1 (regs_complete_d1),
    .alu_start        (alu_start),
    .tag_read         (tag_read),
    .regs_tag         (regs_tag),
    .regs_lane_count  (regs_lane_count),
    .regs_valid       (regs_valid),
    .regs_cntl        (regs_cntl),
    .regs_data        (regs_data)
  );

endmodule

// ==== dv/simd_wrapper_tb.sv ====
//----------------------------------------------------------------------------
// Self-checking testbench for the SIMD wrapper. Each job is one tag plus one
// word per masked lane, spaced so that tag_ready and result_ready are
// honored. rs0 and rs1 only change once all outstanding jobs have drained.
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "simd_wrap_macros.svh"

module simd_wrapper_tb
  import simd_wrap_pkg::*;
();

  localparam int NUM_JOBS        = 30;
  localparam int WATCHDOG_CYCLES = NUM_JOBS * 40 + 600;
  localparam int DRAIN_LIMIT     = 200;

  typedef logic [`NUM_LANES-1:0][`CNTL_WIDTH-1:0] cntl_vec_t;
  typedef logic [`NUM_LANES-1:0][`LANE_WIDTH-1:0] data_vec_t;

  typedef struct packed
  {
    lane_mask_t   valid;
    tag_t         tag;
    lane_count_t  count;
    cntl_vec_t    cntl;
    data_vec_t    data;
  } job_t;

  logic           clk;
  logic           reset;
  lane_data_t     rs0;
  lane_mask_t     rs1;
  logic           tag_valid;
  tag_t           tag;
  option_ptr_t    tag_option_ptr;
  lane_count_t    tag_lane_count;
  logic           tag_ready;
  lane_mask_t     result_valid;
  lane_cntl_t     result_cntl [`NUM_LANES];
  lane_data_t     result_data [`NUM_LANES];
  lane_mask_t     result_ready;
  logic           option_write;
  option_ptr_t    option_address;
  option_entry_t  option_data;
  tag_t           regs_tag;
  lane_count_t    regs_lane_count;
  lane_mask_t     regs_valid;
  lane_cntl_t     regs_cntl [`NUM_LANES];
  lane_data_t     regs_data [`NUM_LANES];
  logic           regs_ready;
  logic           regs_complete;

  integer         seed = 32'h502f_816a;
  job_t           expected_q [$];
  option_entry_t  opt_model [`OPTION_MEM_DEPTH];
  lane_mask_t     cur_mask;
  lane_data_t     cur_scalar;
  tag_t           tag_seq;
  int             error_count;
  int             jobs_seen;
  int             jobs_mark;
  int             test_num;
  int             test_err_start;
  int             tests_failed;
  string          test_name;

  simd_wrapper dut_i (
    .clk             (clk),
    .reset           (reset),
    .rs0             (rs0),
    .rs1             (rs1),
    .tag_valid       (tag_valid),
    .tag             (tag),
    .tag_option_ptr  (tag_option_ptr),
    .tag_lane_count  (tag_lane_count),
    .tag_ready       (tag_ready),
    .result_valid    (result_valid),
    .result_cntl     (result_cntl),
    .result_data     (result_data),
    .result_ready    (result_ready),
    .option_write    (option_write),
    .option_address  (option_address),
    .option_data     (option_data),
    .regs_tag        (regs_tag),
    .regs_lane_count (regs_lane_count),
    .regs_valid      (regs_valid),
    .regs_cntl       (regs_cntl),
    .regs_data       (regs_data),
    .regs_ready      (regs_ready),
    .regs_complete   (regs_complete)
  );

  always #10 clk = ~clk;

  // --------------------------------------------------------------------------
  // Reference model of one job
  // --------------------------------------------------------------------------
  function automatic job_t model_job(input lane_mask_t mask, input option_entry_t entry,
                                     input lane_data_t scalar, input cntl_vec_t cntl,
                                     input data_vec_t data, input tag_t t,
                                     input lane_count_t cnt);
    job_t        j;
    lane_data_t  w;
    j.valid = mask;
    j.tag   = t;
    j.count = cnt;
    j.cntl  = cntl;
    for (int i = 0; i < `NUM_LANES; i++)
    begin
      w = data[i];
      // Disabled entries bypass whatever their opcode
      if (entry.enable)
      begin
        if (entry.operation == ADD_SCALAR)
          w = data[i] + scalar;
        else if (entry.operation == SUB_SCALAR)
          w = data[i] - scalar;
        else if (entry.operation == MAX_SCALAR && scalar > data[i])
          w = scalar;
        else if (entry.operation == AND_SCALAR)
          w = data[i] & scalar;
      end
      j.data[i] = w;
    end
    return j;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < DRAIN_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    assert (expected_q.size() == 0)
    else
    begin
      $display("%0d jobs never came out within %0d cycles", expected_q.size(), DRAIN_LIMIT);
      error_count++;
      expected_q.delete();
    end
    repeat (8) @(posedge clk);
  endtask

  task automatic set_config(input lane_data_t scalar, input lane_mask_t mask);
    wait_drain();
    @(posedge clk);
    rs0 <= scalar;
    rs1 <= mask;
    cur_scalar = scalar;
    cur_mask   = mask;
    repeat (2) @(posedge clk);
  endtask

  task automatic write_option(input option_ptr_t ptr, input logic enable, input simd_op_e op);
    @(posedge clk);
    option_write             <= 1'b1;
    option_address           <= ptr;
    option_data.enable       <= enable;
    option_data.operation    <= op;
    opt_model[ptr].enable    = enable;
    opt_model[ptr].operation = op;
    @(posedge clk);
    option_write <= 1'b0;
  endtask

  // Queue one tag and one word per masked lane with the expected result
  task automatic send_job(input option_ptr_t ptr);
    cntl_vec_t    cntl;
    data_vec_t    data;
    lane_count_t  cnt;
    for (int i = 0; i < `NUM_LANES; i++)
    begin
      cntl[i] = lane_cntl_t'($random(seed));
      data[i] = $random(seed);
    end
    cnt = lane_count_t'($countones(cur_mask));
    @(negedge clk);
    while (!tag_ready || ((result_ready & cur_mask) != cur_mask))
      @(negedge clk);
    @(posedge clk);
    tag_valid      <= 1'b1;
    tag            <= tag_seq;
    tag_option_ptr <= ptr;
    tag_lane_count <= cnt;
    result_valid   <= cur_mask;
    for (int i = 0; i < `NUM_LANES; i++)
    begin
      result_cntl[i] <= cntl[i];
      result_data[i] <= data[i];
    end
    expected_q.push_back(model_job(cur_mask, opt_model[ptr], cur_scalar, cntl, data,
                                   tag_seq, cnt));
    tag_seq++;
    @(posedge clk);
    tag_valid    <= 1'b0;
    result_valid <= '0;
    repeat (3) @(posedge clk);
  endtask

  task automatic begin_test(input string name);
    test_num++;
    test_name      = name;
    test_err_start = error_count;
  endtask

  task automatic end_test();
    if (error_count != test_err_start)
      tests_failed++;
    $display("Test %0d %s: %s", test_num, test_name,
             (error_count == test_err_start) ? "ok" : "FAILED");
  endtask

  // --------------------------------------------------------------------------
  // Upstream responder and output compare
  // --------------------------------------------------------------------------
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (!reset && regs_valid != '0)
      begin
        repeat (2) @(posedge clk);
        regs_complete <= 1'b1;
        repeat (2) @(posedge clk);
        regs_complete <= 1'b0;
      end
    end
  end

  always @(negedge clk)
  begin : compare_block
    job_t exp;
    if (!reset && regs_valid != '0)
    begin
      jobs_seen++;
      assert (expected_q.size() != 0)
      else
      begin
        $display("Upstream output at %0t with no job outstanding", $time);
        error_count++;
      end
      if (expected_q.size() != 0)
      begin
        exp = expected_q.pop_front();
        compare_word("regs_valid", exp.valid, regs_valid);
        compare_word("regs_tag", exp.tag, regs_tag);
        compare_word("regs_lane_count", exp.count, regs_lane_count);
        for (int i = 0; i < `NUM_LANES; i++)
        begin
          if (exp.valid[i])
          begin
            compare_word($sformatf("regs_cntl[%0d]", i), exp.cntl[i], regs_cntl[i]);
            compare_word($sformatf("regs_data[%0d]", i), exp.data[i], regs_data[i]);
          end
        end
      end
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial
  begin
    clk            = 1'b0;
    reset          = 1'b1;
    rs0            = '0;
    rs1            = '0;
    tag_valid      = 1'b0;
    tag            = '0;
    tag_option_ptr = '0;
    tag_lane_count = '0;
    result_valid   = '0;
    option_write   = 1'b0;
    option_address = '0;
    option_data    = '0;
    regs_ready     = 1'b1;
    regs_complete  = 1'b0;
    for (int i = 0; i < `NUM_LANES; i++)
    begin
      result_cntl[i] = '0;
      result_data[i] = '0;
    end
    for (int i = 0; i < `OPTION_MEM_DEPTH; i++)
      opt_model[i] = '0;
    tag_seq = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    begin_test("reset state");
    @(negedge clk);
    compare_word("regs_valid", 32'd0, regs_valid);
    compare_word("tag_ready", 32'd1, tag_ready);
    compare_word("result_ready", {`NUM_LANES{1'b1}}, result_ready);
    end_test();

    // Entry 0 keeps its reset value and entry 6 is disabled with an opcode
    write_option(4'd1, 1'b1, ADD_SCALAR);
    write_option(4'd2, 1'b1, SUB_SCALAR);
    write_option(4'd3, 1'b1, MAX_SCALAR);
    write_option(4'd4, 1'b1, AND_SCALAR);
    write_option(4'd5, 1'b1, PASS);
    write_option(4'd6, 1'b0, ADD_SCALAR);

    begin_test("bypass");
    set_config($random(seed), 4'hf);
    for (int k = 0; k < 4; k++)
      send_job((k % 2 != 0) ? 4'd6 : 4'd0);
    wait_drain();
    end_test();

    begin_test("each opcode");
    for (int p = 1; p <= 5; p++)
    begin
      set_config($random(seed), 4'hf);
      send_job(option_ptr_t'(p));
      send_job(option_ptr_t'(p));
    end
    wait_drain();
    end_test();

    begin_test("back to back tags");
    set_config($random(seed), 4'hf);
    for (int k = 0; k < 8; k++)
      send_job(option_ptr_t'($unsigned($random(seed)) % 7));
    wait_drain();
    end_test();

    begin_test("partial mask");
    jobs_mark = jobs_seen;
    set_config($random(seed), 4'b1011);
    for (int k = 0; k < 4; k++)
      send_job(option_ptr_t'($unsigned($random(seed)) % 7));
    set_config($random(seed), 4'b0100);
    for (int k = 0; k < 2; k++)
      send_job(option_ptr_t'($unsigned($random(seed)) % 7));
    wait_drain();
    compare_word("job count", 32'd6, jobs_seen - jobs_mark);
    end_test();

    begin_test("upstream back-pressure");
    set_config($random(seed), 4'hf);
    @(posedge clk);
    regs_ready <= 1'b0;
    repeat (2) @(posedge clk);
    jobs_mark = jobs_seen;
    send_job(option_ptr_t'($unsigned($random(seed)) % 7));
    send_job(option_ptr_t'($unsigned($random(seed)) % 7));
    repeat (30) @(posedge clk);
    @(negedge clk);
    compare_word("job count", 32'd0, jobs_seen - jobs_mark);
    compare_word("tag_ready", 32'd0, tag_ready);
    @(posedge clk);
    regs_ready <= 1'b1;
    wait_drain();
    compare_word("job count", 32'd2, jobs_seen - jobs_mark);
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d jobs checked, %0d errors",
             test_num, tests_failed, jobs_seen, error_count);
    if (error_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/simd_wrap_pkg.sv
verilog/lane_result_if.sv
verilog/pipelined_fifo.sv
verilog/simd_option_memory.sv
verilog/simd_lane_alu.sv
verilog/upstream_cntl.sv
verilog/simd_wrapper.sv
dv/simd_wrapper_tb.sv
